/* filelist.f */
rtl/ccc_pkg.sv
rtl/ccc_sequencer.sv
rtl/ccc_get_responder.sv
rtl/ccc_set_handler.sv
rtl/ccc_top.sv
dv/ccc_checker.sv
dv/tb_ccc_top.sv

/* Makefile */
# Verilator build and run for the CCC engine testbench

VERILATOR ?= verilator
TOP       ?= tb_ccc_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
PASS_MSG  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dv/tb_ccc_top.sv */
// Testbench for ccc_top with LFSR stimulus, bus-layer model, reference model and timeout
`default_nettype none

module tb_ccc_top
  import ccc_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam byte_t       MrlIbi        = 8'h5C;
  localparam int          NumTrans      = 200;
  localparam int          TimeoutCycles = NumTrans * 60;
  localparam logic [31:0] LfsrSeed      = 32'd96655;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps      = 32'h80200003;

  localparam ccc_code_t CodeList [17] = '{
    CccBcastEnec, CccBcastDisec, CccBcastRstdaa, CccBcastSetmwl, CccBcastSetmrl,
    CccBcastSetaasa, CccDirectEnec, CccDirectDisec, CccDirectSetdasa, CccDirectSetmwl,
    CccDirectSetmrl, CccGetMwl, CccGetMrl, CccGetPid, CccGetBcr, CccGetDcr, CccGetStatus
  };

  logic      clk_i;
  logic      rst_ni;
  ccc_code_t ccc;
  logic      ccc_valid;
  logic      done;
  bus_evt_t  bus_evt;
  bus_done_t bus_done;
  bus_req_t  bus_req;
  dev_addr_t sta_addr;
  logic      sta_valid;
  dev_addr_t dyn_addr;
  logic      dyn_valid;
  csr_get_t  csr_get;
  csr_set_t  csr_set;

  logic [31:0] lfsr;
  int          cycles;
  byte_t       get_q[$];

  // Reference model expectations for one CCC
  int         exp_rstdaa_n;
  int         exp_dasa_n;
  int         exp_mwl_n;
  int         exp_mrl_n;
  dev_addr_t  exp_dasa;
  len_t       exp_mwl;
  len_t       exp_mrl;
  logic [2:0] exp_enec;
  logic [2:0] exp_disec;

  // Pulses seen on csr_set_o
  int        rstdaa_n;
  int        dasa_n;
  int        mwl_n;
  int        mrl_n;
  dev_addr_t seen_dasa;
  len_t      seen_mwl;
  len_t      seen_mrl;

  ccc_top #(
    .MrlIbiSize (MrlIbi)
  ) dut0 (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ccc_i            (ccc),
    .ccc_valid_i      (ccc_valid),
    .done_o           (done),
    .bus_evt_i        (bus_evt),
    .bus_done_i       (bus_done),
    .bus_req_o        (bus_req),
    .sta_addr_i       (sta_addr),
    .sta_addr_valid_i (sta_valid),
    .dyn_addr_i       (dyn_addr),
    .dyn_addr_valid_i (dyn_valid),
    .csr_get_i        (csr_get),
    .csr_set_o        (csr_set)
  );

  bind ccc_top ccc_checker u_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .bus_req_i (bus_req_o),
    .bus_evt_i (bus_evt_i),
    .done_i    (done_o),
    .csr_set_i (csr_set_o)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Timeout: the run hung and did not finish within %0d cycles", cycles);
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // Count write pulses in mid cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (csr_set.rstdaa) begin
        rstdaa_n++;
      end
      if (csr_set.set_dasa) begin
        dasa_n++;
        seen_dasa = csr_set.dasa;
      end
      if (csr_set.set_mwl) begin
        mwl_n++;
        seen_mwl = csr_set.mwl;
      end
      if (csr_set.set_mrl) begin
        mrl_n++;
        seen_mrl = csr_set.mrl;
      end
    end
  end

  task automatic check_eq(input string name, input logic [47:0] exp, input logic [47:0] act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected 0x%0h got 0x%0h", $time, name, exp, act);
      $display("*** FAILED ***");
      $fatal(1, "Value check on %s", name);
    end
  endtask

  // One Galois step per random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LfsrTaps) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic dev_addr_t rand_addr();
    dev_addr_t a;
    a = 7'(rand_bits(7));
    // Own addresses never collide with the broadcast address
    if (a == RsvdAddr) begin
      a = 7'h2A;
    end
    return a;
  endfunction

  function automatic logic addr_matches(input dev_addr_t a);
    if (dyn_valid) begin
      return a == dyn_addr;
    end
    if (sta_valid) begin
      return a == sta_addr;
    end
    return 1'b0;
  endfunction

  function automatic int data_len(input ccc_code_t code);
    if (code inside {CccBcastSetmwl, CccBcastSetmrl, CccDirectSetmwl, CccDirectSetmrl}) begin
      return 2;
    end
    if (code inside {CccBcastEnec, CccBcastDisec, CccDirectEnec, CccDirectDisec,
                     CccDirectSetdasa}) begin
      return 1;
    end
    return 0;
  endfunction

  // Response bytes, most significant first
  function automatic void build_get_bytes(input ccc_code_t code);
    int i;
    get_q.delete();
    case (code)
      CccGetBcr: get_q.push_back(csr_get.bcr);
      CccGetDcr: get_q.push_back(csr_get.dcr);
      CccGetMwl: begin
        get_q.push_back(csr_get.mwl[15:8]);
        get_q.push_back(csr_get.mwl[7:0]);
      end
      CccGetStatus: begin
        get_q.push_back(csr_get.status[15:8]);
        get_q.push_back(csr_get.status[7:0]);
      end
      CccGetMrl: begin
        get_q.push_back(csr_get.mrl[15:8]);
        get_q.push_back(csr_get.mrl[7:0]);
        get_q.push_back(MrlIbi);
      end
      CccGetPid: begin
        for (i = 5; i >= 0; i--) begin
          get_q.push_back(csr_get.pid[i*8 +: 8]);
        end
      end
      default: get_q.delete();
    endcase
  endfunction

  function automatic void apply_tbit(input ccc_code_t code);
    if (code == CccBcastRstdaa) begin
      exp_rstdaa_n = 1;
    end
    if (code == CccBcastSetaasa) begin
      exp_dasa_n = 1;
      exp_dasa   = sta_addr;
    end
  endfunction

  function automatic void apply_write(input ccc_code_t code, input byte_t b0, input byte_t b1);
    if (code inside {CccBcastEnec, CccDirectEnec}) begin
      exp_enec = {b0[3], b0[1], b0[0]};
    end
    if (code inside {CccBcastDisec, CccDirectDisec}) begin
      exp_disec = {b0[3], b0[1], b0[0]};
    end
    if (code inside {CccBcastSetmwl, CccDirectSetmwl}) begin
      exp_mwl_n = 1;
      exp_mwl   = {b0, b1};
    end
    if (code inside {CccBcastSetmrl, CccDirectSetmrl}) begin
      exp_mrl_n = 1;
      exp_mrl   = {b0, b1};
    end
    if (code == CccDirectSetdasa) begin
      exp_dasa_n = 1;
      exp_dasa   = b0[7:1];
    end
  endfunction

  // All tasks below start and end on a falling edge
  task automatic wait_request();
    while (!(bus_req.rx_bit || bus_req.rx_byte || bus_req.tx_bit || bus_req.tx_byte))
      @(negedge clk_i);
  endtask

  task automatic serve_rx(input logic want_byte, input byte_t data);
    logic [31:0] delay;
    wait_request();
    check_eq("bus_req_o.rx_byte", 48'(want_byte), 48'(bus_req.rx_byte));
    check_eq("bus_req_o.rx_bit", 48'(!want_byte), 48'(bus_req.rx_bit));
    check_eq("bus_req_o.sel_pp", 48'(0), 48'(bus_req.sel_pp));
    delay = rand_bits(2);
    repeat (delay[1:0]) @(negedge clk_i);
    bus_done.rx_data = data;
    bus_done.rx_done = 1'b1;
    @(negedge clk_i);
    bus_done.rx_done = 1'b0;
  endtask

  task automatic serve_tx(input logic want_byte, input logic want_pp, output byte_t value);
    logic [31:0] delay;
    wait_request();
    check_eq("bus_req_o.tx_byte", 48'(want_byte), 48'(bus_req.tx_byte));
    check_eq("bus_req_o.tx_bit", 48'(!want_byte), 48'(bus_req.tx_bit));
    check_eq("bus_req_o.sel_pp", 48'(want_pp), 48'(bus_req.sel_pp));
    delay = rand_bits(2);
    repeat (delay[1:0]) @(negedge clk_i);
    value = bus_req.tx_value;
    bus_done.tx_done = 1'b1;
    @(negedge clk_i);
    bus_done.tx_done = 1'b0;
  endtask

  task automatic send_rstart();
    bus_evt.rstart = 1'b1;
    @(negedge clk_i);
    bus_evt.rstart = 1'b0;
  endtask

  task automatic send_start();
    bus_evt.start = 1'b1;
    @(negedge clk_i);
    bus_evt.start = 1'b0;
  endtask

  task automatic send_stop();
    bus_evt.stop = 1'b1;
    @(negedge clk_i);
    bus_evt.stop = 1'b0;
  endtask

  // The T-bit request follows one cycle after the accepted command
  task automatic start_ccc(input ccc_code_t code);
    ccc       = code;
    ccc_valid = 1'b1;
    @(negedge clk_i);
    ccc_valid = 1'b0;
    check_eq("bus_req_o.rx_bit", 48'(1), 48'(bus_req.rx_bit));
  endtask

  // Wait for done, then for WaitCcc, and compare the model
  task automatic finish_ccc();
    while (!done)
      @(negedge clk_i);
    @(negedge clk_i);
    check_eq("done_o", 48'(0), 48'(done));
    @(negedge clk_i);
    check_eq("rstdaa pulses", 48'(exp_rstdaa_n), 48'(rstdaa_n));
    check_eq("set_dasa pulses", 48'(exp_dasa_n), 48'(dasa_n));
    check_eq("set_mwl pulses", 48'(exp_mwl_n), 48'(mwl_n));
    check_eq("set_mrl pulses", 48'(exp_mrl_n), 48'(mrl_n));
    if (exp_dasa_n == 1) begin
      check_eq("csr_set_o.dasa", 48'(exp_dasa), 48'(seen_dasa));
    end
    if (exp_mwl_n == 1) begin
      check_eq("csr_set_o.mwl", 48'(exp_mwl), 48'(seen_mwl));
    end
    if (exp_mrl_n == 1) begin
      check_eq("csr_set_o.mrl", 48'(exp_mrl), 48'(seen_mrl));
    end
    check_eq("csr_set_o.enec", 48'(exp_enec),
             48'({csr_set.enec_hj, csr_set.enec_crr, csr_set.enec_ibi}));
    check_eq("csr_set_o.disec", 48'(exp_disec),
             48'({csr_set.disec_hj, csr_set.disec_crr, csr_set.disec_ibi}));
  endtask

  task automatic write_bytes(input ccc_code_t code);
    byte_t b0;
    byte_t b1;
    b0 = 8'(rand_bits(8));
    b1 = 8'(rand_bits(8));
    if (data_len(code) >= 1) begin
      serve_rx(1'b1, b0);
      serve_rx(1'b0, 8'h00);
    end
    if (data_len(code) == 2) begin
      serve_rx(1'b1, b1);
      serve_rx(1'b0, 8'h00);
    end
    apply_write(code, b0, b1);
  endtask

  task automatic run_broadcast(input ccc_code_t code);
    start_ccc(code);
    serve_rx(1'b0, 8'h00);
    apply_tbit(code);
    write_bytes(code);
    send_stop();
    check_eq("done_o after stop", 48'(1), 48'(done));
    finish_ccc();
  endtask

  task automatic run_direct(input ccc_code_t code);
    logic [31:0] pick;
    dev_addr_t   addr;
    logic        rnw;
    logic        match;
    byte_t       v;
    int          i;
    start_ccc(code);
    serve_rx(1'b0, 8'h00);
    send_rstart();
    // Mostly own addresses so that ACKs are common
    pick = rand_bits(2);
    if (pick[1:0] == 2'd2) begin
      addr = sta_addr;
    end else if (pick[1:0] == 2'd3) begin
      addr = rand_addr();
    end else begin
      addr = dyn_addr;
    end
    rnw   = code inside {CccGetMwl, CccGetMrl, CccGetPid, CccGetBcr, CccGetDcr, CccGetStatus};
    match = addr_matches(addr);
    serve_rx(1'b1, {addr, rnw});
    serve_tx(1'b0, 1'b0, v);
    check_eq("address ACK bit", 48'(!match), 48'(v[0]));
    if (match && rnw) begin
      build_get_bytes(code);
      for (i = 0; i < get_q.size(); i++) begin
        serve_tx(1'b1, 1'b1, v);
        check_eq("GET data byte", 48'(get_q[i]), 48'(v));
        serve_tx(1'b0, 1'b1, v);
        check_eq("GET T-bit", 48'(i != get_q.size() - 1), 48'(v[0]));
      end
    end else if (match) begin
      write_bytes(code);
    end
    // 7E/W closes the direct part, after either a start or a repeated start
    pick = rand_bits(1);
    if (pick[0]) begin
      send_start();
    end else begin
      send_rstart();
    end
    serve_rx(1'b1, {RsvdAddr, 1'b0});
    serve_tx(1'b0, 1'b0, v);
    check_eq("ACK bit for 7E", 48'(1), 48'(v[0]));
    finish_ccc();
  endtask

  task automatic run_stop(input ccc_code_t code);
    logic [31:0] r;
    int          phases;
    byte_t       b;
    r      = rand_bits(2);
    phases = (r[1:0] == 2'd3) ? 0 : int'(r[1:0]);
    if (code[7] && phases > 1) begin
      phases = 1;
    end
    start_ccc(code);
    if (phases >= 1) begin
      serve_rx(1'b0, 8'h00);
      apply_tbit(code);
    end
    if (phases >= 2) begin
      b = 8'(rand_bits(8));
      serve_rx(1'b1, b);
      serve_rx(1'b0, 8'h00);
      if (data_len(code) == 1) begin
        apply_write(code, b, 8'h00);
      end
    end
    // Stop may hit while a request is still pending
    r = rand_bits(2);
    repeat (r[1:0]) @(negedge clk_i);
    send_stop();
    check_eq("done_o after stop", 48'(1), 48'(done));
    finish_ccc();
  endtask

  task automatic new_environment();
    dyn_addr       = rand_addr();
    sta_addr       = rand_addr();
    dyn_valid      = (rand_bits(2) != 0);
    sta_valid      = (rand_bits(1) != 0);
    csr_get.bcr    = 8'(rand_bits(8));
    csr_get.dcr    = 8'(rand_bits(8));
    csr_get.mwl    = 16'(rand_bits(16));
    csr_get.mrl    = 16'(rand_bits(16));
    csr_get.pid    = {24'(rand_bits(24)), 24'(rand_bits(24))};
    csr_get.status = 16'(rand_bits(16));
    exp_rstdaa_n   = 0;
    exp_dasa_n     = 0;
    exp_mwl_n      = 0;
    exp_mrl_n      = 0;
    rstdaa_n       = 0;
    dasa_n         = 0;
    mwl_n          = 0;
    mrl_n          = 0;
  endtask

  initial begin
    int        t;
    ccc_code_t code;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    ccc       = '0;
    ccc_valid = 1'b0;
    bus_evt   = '0;
    bus_done  = '0;
    sta_addr  = '0;
    sta_valid = 1'b0;
    dyn_addr  = '0;
    dyn_valid = 1'b0;
    csr_get   = '0;
    cycles    = 0;
    lfsr      = LfsrSeed;
    exp_enec  = '0;
    exp_disec = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_eq("bus_req_o after reset", 48'(0), 48'(bus_req));
    check_eq("done_o after reset", 48'(0), 48'(done));
    check_eq("set pulses after reset", 48'(0),
             48'({csr_set.rstdaa, csr_set.set_dasa, csr_set.set_mwl, csr_set.set_mrl}));
    for (t = 0; t < NumTrans; t++) begin
      new_environment();
      code = CodeList[rand_bits(5) % 17];
      if (rand_bits(3) == 0) begin
        run_stop(code);
      end else if (code[7]) begin
        run_direct(code);
      end else begin
        run_broadcast(code);
      end
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/ccc_checker.sv */
// Bound assertions on bus requests, set pulses, stop handling and reset values
`default_nettype none

module ccc_checker
  import ccc_pkg::*;
(
  input wire logic     clk_i,
  input wire logic     rst_ni,
  input wire bus_req_t bus_req_i,
  input wire bus_evt_t bus_evt_i,
  input wire logic     done_i,
  input wire csr_set_t csr_set_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [3:0] req_bits;

  assign req_bits = {bus_req_i.rx_bit, bus_req_i.rx_byte, bus_req_i.tx_bit, bus_req_i.tx_byte};

  // Only one request toward the bus layer at a time
  req_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(req_bits))
    else $error("More than one bus request is active");

  // Write pulses never stretch
  rstdaa_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_set_i.rstdaa |=> !csr_set_i.rstdaa)
    else $error("rstdaa pulse longer than one cycle");
  dasa_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_set_i.set_dasa |=> !csr_set_i.set_dasa)
    else $error("set_dasa pulse longer than one cycle");
  mwl_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_set_i.set_mwl |=> !csr_set_i.set_mwl)
    else $error("set_mwl pulse longer than one cycle");
  mrl_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_set_i.set_mrl |=> !csr_set_i.set_mrl)
    else $error("set_mrl pulse longer than one cycle");

  // Stop forces the end of the CCC on the next edge
  stop_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_evt_i.stop |=> done_i)
    else $error("done_o missing one cycle after stop");

  // Quiet bus side coming out of reset
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |=> (bus_req_i == '0) && !done_i)
    else $error("Requests or done active after reset");

endmodule

`default_nettype wire

/* rtl/ccc_top.sv */
// CCC engine top joining the sequencer, GET responder and SET handler
`default_nettype none

module ccc_top
  import ccc_pkg::*;
#(
  // Third GETMRL byte
  parameter byte_t MrlIbiSize = 8'hFF
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire ccc_code_t ccc_i,
  input  wire logic      ccc_valid_i,
  output logic           done_o,
  input  wire bus_evt_t  bus_evt_i,
  input  wire bus_done_t bus_done_i,
  output bus_req_t       bus_req_o,
  input  wire dev_addr_t sta_addr_i,
  input  wire logic      sta_addr_valid_i,
  input  wire dev_addr_t dyn_addr_i,
  input  wire logic      dyn_addr_valid_i,
  input  wire csr_get_t  csr_get_i,
  output csr_set_t       csr_set_o
);

  ccc_code_t cmd;
  logic      cmd_start;
  logic      tbit_done;
  logic      data_strobe;
  byte_t     data_byte;
  logic      tx_load;
  logic      tx_adv;
  byte_t     tx_byte;
  logic      tx_last;

  ccc_sequencer u_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ccc_i            (ccc_i),
    .ccc_valid_i      (ccc_valid_i),
    .done_o           (done_o),
    .bus_evt_i        (bus_evt_i),
    .bus_done_i       (bus_done_i),
    .bus_req_o        (bus_req_o),
    .sta_addr_i       (sta_addr_i),
    .sta_addr_valid_i (sta_addr_valid_i),
    .dyn_addr_i       (dyn_addr_i),
    .dyn_addr_valid_i (dyn_addr_valid_i),
    .tx_byte_i        (tx_byte),
    .tx_last_i        (tx_last),
    .tx_load_o        (tx_load),
    .tx_adv_o         (tx_adv),
    .cmd_o            (cmd),
    .cmd_start_o      (cmd_start),
    .tbit_done_o      (tbit_done),
    .data_strobe_o    (data_strobe),
    .data_byte_o      (data_byte)
  );

  ccc_get_responder #(
    .MrlIbiSize (MrlIbiSize)
  ) u_get_responder (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cmd_i     (cmd),
    .tx_load_i (tx_load),
    .tx_adv_i  (tx_adv),
    .csr_get_i (csr_get_i),
    .tx_byte_o (tx_byte),
    .tx_last_o (tx_last)
  );

  ccc_set_handler u_set_handler (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (cmd),
    .cmd_start_i   (cmd_start),
    .tbit_done_i   (tbit_done),
    .data_strobe_i (data_strobe),
    .data_byte_i   (data_byte),
    .sta_addr_i    (sta_addr_i),
    .csr_set_o     (csr_set_o)
  );

endmodule

`default_nettype wire

/* rtl/ccc_set_handler.sv */
// Data byte counter and CSR write registers for SET and broadcast CCCs
`default_nettype none

module ccc_set_handler
  import ccc_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire ccc_code_t cmd_i,
  input  wire logic      cmd_start_i,
  input  wire logic      tbit_done_i,
  input  wire logic      data_strobe_i,
  input  wire byte_t     data_byte_i,
  input  wire dev_addr_t sta_addr_i,
  output csr_set_t       csr_set_o
);

  cnt_t      cnt_q;
  logic      first_byte;
  logic      second_byte;
  logic      set_mwl_q;
  logic      set_mrl_q;
  logic      rstdaa_q;
  logic      set_dasa_q;
  len_t      mwl_q;
  len_t      mrl_q;
  dev_addr_t dasa_q;
  logic [2:0] enec_q;
  logic [2:0] disec_q;

  // Index of the byte being strobed, saturates at the top
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (cmd_start_i) begin
      cnt_q <= '0;
    end else if (data_strobe_i && cnt_q != '1) begin
      cnt_q <= cnt_q + 4'd1;
    end
  end

  assign first_byte  = data_strobe_i && (cnt_q == 4'd0);
  assign second_byte = data_strobe_i && (cnt_q == 4'd1);

  // One-cycle write pulses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      set_mwl_q  <= 1'b0;
      set_mrl_q  <= 1'b0;
      rstdaa_q   <= 1'b0;
      set_dasa_q <= 1'b0;
    end else begin
      set_mwl_q  <= second_byte && (cmd_i inside {CccBcastSetmwl, CccDirectSetmwl});
      set_mrl_q  <= second_byte && (cmd_i inside {CccBcastSetmrl, CccDirectSetmrl});
      rstdaa_q   <= tbit_done_i && (cmd_i == CccBcastRstdaa);
      // SETAASA after the T-bit, SETDASA after its data byte
      set_dasa_q <= (tbit_done_i && (cmd_i == CccBcastSetaasa)) ||
                    (first_byte && (cmd_i == CccDirectSetdasa));
    end
  end

  // Lengths arrive MSB first
  always_ff @(posedge clk_i) begin
    if (cmd_i inside {CccBcastSetmwl, CccDirectSetmwl}) begin
      if (first_byte) mwl_q[15:8] <= data_byte_i;
      if (second_byte) mwl_q[7:0] <= data_byte_i;
    end
    if (cmd_i inside {CccBcastSetmrl, CccDirectSetmrl}) begin
      if (first_byte) mrl_q[15:8] <= data_byte_i;
      if (second_byte) mrl_q[7:0] <= data_byte_i;
    end
  end

  // Static address for SETAASA, data byte for SETDASA
  always_ff @(posedge clk_i) begin
    if (tbit_done_i && (cmd_i == CccBcastSetaasa)) begin
      dasa_q <= sta_addr_i;
    end else if (first_byte && (cmd_i == CccDirectSetdasa)) begin
      dasa_q <= data_byte_i[7:1];
    end
  end

  // Event flags hold until the next ENEC or DISEC
  // Bits 0, 1 and 3 map to IBI, CRR and HJ
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enec_q  <= '0;
      disec_q <= '0;
    end else if (first_byte) begin
      if (cmd_i inside {CccBcastEnec, CccDirectEnec}) begin
        enec_q <= {data_byte_i[3], data_byte_i[1], data_byte_i[0]};
      end
      if (cmd_i inside {CccBcastDisec, CccDirectDisec}) begin
        disec_q <= {data_byte_i[3], data_byte_i[1], data_byte_i[0]};
      end
    end
  end

  always_comb begin
    csr_set_o.set_mwl   = set_mwl_q;
    csr_set_o.mwl       = mwl_q;
    csr_set_o.set_mrl   = set_mrl_q;
    csr_set_o.mrl       = mrl_q;
    csr_set_o.enec_ibi  = enec_q[0];
    csr_set_o.enec_crr  = enec_q[1];
    csr_set_o.enec_hj   = enec_q[2];
    csr_set_o.disec_ibi = disec_q[0];
    csr_set_o.disec_crr = disec_q[1];
    csr_set_o.disec_hj  = disec_q[2];
    csr_set_o.rstdaa    = rstdaa_q;
    csr_set_o.set_dasa  = set_dasa_q;
    csr_set_o.dasa      = dasa_q;
  end

endmodule

`default_nettype wire

/* rtl/ccc_get_responder.sv */
// Direct GET response byte counter and byte select
`default_nettype none

module ccc_get_responder
  import ccc_pkg::*;
#(
  parameter byte_t MrlIbiSize = 8'hFF
) (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire ccc_code_t cmd_i,
  input  wire logic      tx_load_i,
  input  wire logic      tx_adv_i,
  input  wire csr_get_t  csr_get_i,
  output byte_t          tx_byte_o,
  output logic           tx_last_o
);

  cnt_t cnt_q;
  cnt_t len;

  // Response length per command
  always_comb begin
    case (cmd_i)
      CccGetBcr, CccGetDcr:    len = 4'd1;
      CccGetMwl, CccGetStatus: len = 4'd2;
      CccGetMrl:               len = 4'd3;
      CccGetPid:               len = 4'd6;
      default:                 len = 4'd0;
    endcase
  end

  // Counts remaining bytes, no wrap below zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (tx_load_i) begin
      cnt_q <= len;
    end else if (tx_adv_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 4'd1;
    end
  end

  assign tx_last_o = (cnt_q == '0);

  // MSB first, higher count selects the upper byte
  always_comb begin
    tx_byte_o = '0;
    case (cmd_i)
      CccGetBcr: tx_byte_o = csr_get_i.bcr;
      CccGetDcr: tx_byte_o = csr_get_i.dcr;
      CccGetMwl: begin
        tx_byte_o = (cnt_q == 4'd2) ? csr_get_i.mwl[15:8] : csr_get_i.mwl[7:0];
      end
      CccGetStatus: begin
        tx_byte_o = (cnt_q == 4'd2) ? csr_get_i.status[15:8] : csr_get_i.status[7:0];
      end
      CccGetMrl: begin
        case (cnt_q)
          4'd3:    tx_byte_o = csr_get_i.mrl[15:8];
          4'd2:    tx_byte_o = csr_get_i.mrl[7:0];
          // Max IBI payload size
          default: tx_byte_o = MrlIbiSize;
        endcase
      end
      CccGetPid: begin
        case (cnt_q)
          4'd6:    tx_byte_o = csr_get_i.pid[47:40];
          4'd5:    tx_byte_o = csr_get_i.pid[39:32];
          4'd4:    tx_byte_o = csr_get_i.pid[31:24];
          4'd3:    tx_byte_o = csr_get_i.pid[23:16];
          4'd2:    tx_byte_o = csr_get_i.pid[15:8];
          default: tx_byte_o = csr_get_i.pid[7:0];
        endcase
      end
      default: tx_byte_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ccc_sequencer.sv */
// CCC FSM with command register, direct address capture and match, bus requests
`default_nettype none

module ccc_sequencer
  import ccc_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // Command handoff from the primary target FSM
  input  wire ccc_code_t ccc_i,
  input  wire logic      ccc_valid_i,
  output logic           done_o,
  // Bus layer
  input  wire bus_evt_t  bus_evt_i,
  input  wire bus_done_t bus_done_i,
  output bus_req_t       bus_req_o,
  // Own addresses
  input  wire dev_addr_t sta_addr_i,
  input  wire logic      sta_addr_valid_i,
  input  wire dev_addr_t dyn_addr_i,
  input  wire logic      dyn_addr_valid_i,
  // GET responder
  input  wire byte_t     tx_byte_i,
  input  wire logic      tx_last_i,
  output logic           tx_load_o,
  output logic           tx_adv_o,
  // SET handler
  output ccc_code_t      cmd_o,
  output logic           cmd_start_o,
  output logic           tbit_done_o,
  output logic           data_strobe_o,
  output byte_t          data_byte_o
);

  seq_state_e state_q, state_d;

  ccc_code_t cmd_q;
  byte_t     data_byte_q;
  dev_addr_t addr_q;
  logic      rnw_q;
  logic      nacked_q;
  logic      addr_match;
  logic      addr_rsvd;
  logic      is_direct;
  logic      rx_done;
  logic      tx_done;
  logic      new_frame;

  assign rx_done   = bus_done_i.rx_done;
  assign tx_done   = bus_done_i.tx_done;
  assign new_frame = bus_evt_i.start | bus_evt_i.rstart;
  assign is_direct = cmd_q[7];

  // Accepted only while waiting for a command
  assign cmd_start_o = ccc_valid_i && (state_q == WaitCcc);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q <= '0;
    end else if (cmd_start_o) begin
      cmd_q <= ccc_i;
    end
  end

  // Data byte for the SET handler
  always_ff @(posedge clk_i) begin
    if (state_q == RxData && rx_done) begin
      data_byte_q <= bus_done_i.rx_data;
    end
  end

  // Address and R/W bit after a repeated start
  always_ff @(posedge clk_i) begin
    if (state_q == RxDirectAddr && rx_done) begin
      addr_q <= bus_done_i.rx_data[7:1];
      rnw_q  <= bus_done_i.rx_data[0];
    end
  end

  // Dynamic address wins, static only as fallback
  always_comb begin
    if (dyn_addr_valid_i) begin
      addr_match = (addr_q == dyn_addr_i);
    end else if (sta_addr_valid_i) begin
      addr_match = (addr_q == sta_addr_i);
    end else begin
      addr_match = 1'b0;
    end
  end

  // 7E/W ends the direct part
  assign addr_rsvd = (addr_q == RsvdAddr) && !rnw_q;

  // After a NACK bit, wait quietly for the next frame
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nacked_q <= 1'b0;
    end else if (state_q != TxAddrAck) begin
      nacked_q <= 1'b0;
    end else if (tx_done && !addr_match) begin
      nacked_q <= 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: state_d = WaitCcc;
      WaitCcc: begin
        if (ccc_valid_i) state_d = RxTbit;
      end
      RxTbit: begin
        if (rx_done) state_d = is_direct ? WaitSr : RxData;
      end
      WaitSr: begin
        if (bus_evt_i.rstart) state_d = RxDirectAddr;
      end
      RxDirectAddr: begin
        if (rx_done) state_d = TxAddrAck;
      end
      TxAddrAck: begin
        if (new_frame) begin
          state_d = RxDirectAddr;
        end else if (tx_done && !nacked_q) begin
          if (addr_rsvd) state_d = DoneCcc;
          else if (addr_match && rnw_q) state_d = TxData;
          else if (addr_match) state_d = RxData;
        end
      end
      RxData: begin
        if (new_frame) state_d = RxDirectAddr;
        else if (rx_done) state_d = RxDataTbit;
      end
      RxDataTbit: begin
        if (new_frame) state_d = RxDirectAddr;
        else if (rx_done) state_d = RxData;
      end
      TxData: begin
        if (new_frame) state_d = RxDirectAddr;
        else if (tx_done) state_d = TxDataTbit;
      end
      TxDataTbit: begin
        if (new_frame) state_d = RxDirectAddr;
        else if (tx_done) state_d = tx_last_i ? RxDirectAddr : TxData;
      end
      DoneCcc: state_d = Idle;
      default: state_d = Idle;
    endcase
  end

  // Stop overrides every state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (bus_evt_i.stop) begin
      state_q <= DoneCcc;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    bus_req_o = '0;
    unique case (state_q)
      RxTbit, RxDataTbit: bus_req_o.rx_bit = 1'b1;
      RxData, RxDirectAddr: bus_req_o.rx_byte = 1'b1;
      TxAddrAck: begin
        bus_req_o.tx_bit   = !nacked_q;
        // ACK is driven low
        bus_req_o.tx_value = {7'b0, !addr_match};
      end
      TxData: begin
        bus_req_o.tx_byte  = 1'b1;
        bus_req_o.tx_value = tx_byte_i;
        bus_req_o.sel_pp   = 1'b1;
      end
      TxDataTbit: begin
        // T-bit high means more bytes follow
        bus_req_o.tx_bit   = 1'b1;
        bus_req_o.tx_value = {7'b0, !tx_last_i};
        bus_req_o.sel_pp   = 1'b1;
      end
      default: bus_req_o = '0;
    endcase
  end

  assign done_o        = (state_q == DoneCcc);
  assign tx_load_o     = (state_q == TxAddrAck);
  assign tx_adv_o      = (state_q == TxData) && tx_done;
  assign tbit_done_o   = (state_q == RxTbit) && rx_done;
  assign data_strobe_o = (state_q == RxDataTbit) && rx_done;
  assign data_byte_o   = data_byte_q;
  assign cmd_o         = cmd_q;

endmodule

`default_nettype wire

/* rtl/ccc_pkg.sv */
// CCC command codes, width typedefs, sequencer state enum, bus and CSR structs
`default_nettype none

package ccc_pkg;

  // Width types
  typedef logic [7:0]  ccc_code_t;
  typedef logic [7:0]  byte_t;
  typedef logic [6:0]  dev_addr_t;
  typedef logic [15:0] len_t;
  typedef logic [47:0] pid_t;
  // Largest response is GETPID at 6 bytes
  typedef logic [3:0]  cnt_t;

  // Broadcast codes, bit 7 clear
  localparam ccc_code_t CccBcastEnec    = 8'h00;
  localparam ccc_code_t CccBcastDisec   = 8'h01;
  localparam ccc_code_t CccBcastRstdaa  = 8'h06;
  localparam ccc_code_t CccBcastSetmwl  = 8'h09;
  localparam ccc_code_t CccBcastSetmrl  = 8'h0A;
  localparam ccc_code_t CccBcastSetaasa = 8'h29;

  // Direct codes, bit 7 set
  localparam ccc_code_t CccDirectEnec   = 8'h80;
  localparam ccc_code_t CccDirectDisec  = 8'h81;
  localparam ccc_code_t CccDirectSetdasa = 8'h87;
  localparam ccc_code_t CccDirectSetmwl = 8'h89;
  localparam ccc_code_t CccDirectSetmrl = 8'h8A;
  localparam ccc_code_t CccGetMwl       = 8'h8B;
  localparam ccc_code_t CccGetMrl       = 8'h8C;
  localparam ccc_code_t CccGetPid       = 8'h8D;
  localparam ccc_code_t CccGetBcr       = 8'h8E;
  localparam ccc_code_t CccGetDcr       = 8'h8F;
  localparam ccc_code_t CccGetStatus    = 8'h90;

  // Broadcast address, also ends a direct CCC when sent with W
  localparam dev_addr_t RsvdAddr = 7'h7E;

  // One-cycle bus monitor events
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_evt_t;

  // Requests to the bus layer, held until the matching done
  typedef struct packed {
    logic  rx_bit;
    logic  rx_byte;
    logic  tx_bit;
    logic  tx_byte;
    byte_t tx_value;
    // Push-pull drive for read data
    logic  sel_pp;
  } bus_req_t;

  // Bus layer completion pulses
  typedef struct packed {
    logic  rx_done;
    logic  tx_done;
    byte_t rx_data;
  } bus_done_t;

  // Values returned by direct GET CCCs
  typedef struct packed {
    byte_t       bcr;
    byte_t       dcr;
    len_t        mwl;
    len_t        mrl;
    pid_t        pid;
    logic [15:0] status;
  } csr_get_t;

  // CSR writes from SET and broadcast CCCs
  typedef struct packed {
    logic      set_mwl;
    len_t      mwl;
    logic      set_mrl;
    len_t      mrl;
    logic      enec_ibi;
    logic      enec_crr;
    logic      enec_hj;
    logic      disec_ibi;
    logic      disec_crr;
    logic      disec_hj;
    logic      rstdaa;
    logic      set_dasa;
    dev_addr_t dasa;
  } csr_set_t;

  typedef enum logic [3:0] {
    Idle,
    WaitCcc,
    RxTbit,
    RxData,
    RxDataTbit,
    WaitSr,
    RxDirectAddr,
    TxAddrAck,
    TxData,
    TxDataTbit,
    DoneCcc
  } seq_state_e;

endpackage

`default_nettype wire
